/* Bender.yml */
package:
  name: csr_file

sources:
  - common/csr_pkg.sv
  - exception/csr_exception_regs.sv
  - timer/csr_timer.sv
  - source/csr_read_mux.sv
  - source/csr_file.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/csr_file_tb.sv

/* common/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int DATA_W     = 32;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int INT_W      = 13;
    localparam int SWI_W      = 2;

    // Instruction fetch flavour of ADE
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h0;

    // Timer interrupt slot in ESTAT.IS
    localparam int TIMER_INT_BIT = 11;

    // EENTRY is 64-byte aligned
    localparam int EENTRY_LSB = 6;

    // Counter parked here when stopped
    localparam logic [DATA_W-1:0] TIMER_IDLE = 32'hffff_ffff;

    // CRMD fields, PRMD keeps PPLV and PIE at the same spots
    localparam int PLV_W         = 2;
    localparam int DAT_W         = 2;
    localparam int CRMD_PLV_LSB  = 0;
    localparam int CRMD_IE_BIT   = 2;
    localparam int CRMD_DA_BIT   = 3;
    localparam int CRMD_PG_BIT   = 4;
    localparam int CRMD_DATF_LSB = 5;
    localparam int CRMD_DATM_LSB = 7;

    // TCFG and TICLR fields
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;

    // Reset values
    localparam logic [PLV_W-1:0] CRMD_PLV_RST = 2'b00;
    localparam logic             CRMD_IE_RST  = 1'b0;
    localparam logic             CRMD_DA_RST  = 1'b1;
    localparam logic             CRMD_PG_RST  = 1'b0;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_PIL  = 6'h01,
        ECODE_PIS  = 6'h02,
        ECODE_PIF  = 6'h03,
        ECODE_PME  = 6'h04,
        ECODE_PPI  = 6'h07,
        ECODE_ADE  = 6'h08,
        ECODE_ALE  = 6'h09,
        ECODE_TLBR = 6'h3f
    } ecode_e;

endpackage

/* exception/csr_exception_regs.sv */
module csr_exception_regs (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               csr_we,
    input  csr_pkg::csr_num_e                  csr_num,
    input  logic [csr_pkg::DATA_W-1:0]         csr_wvalue,
    input  logic [csr_pkg::DATA_W-1:0]         csr_wmask,
    input  logic                               ex_valid,
    input  logic                               ertn_flush,
    input  logic [csr_pkg::DATA_W-1:0]         ex_pc,
    input  logic [csr_pkg::DATA_W-1:0]         ex_vaddr,
    input  csr_pkg::ecode_e                    ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]     esubcode,
    input  logic                               timer_int,
    output logic [csr_pkg::DATA_W-1:0]         exc_rdata,
    output logic                               exc_hit,
    output logic [csr_pkg::DATA_W-1:0]         ex_entry,
    output logic [csr_pkg::DATA_W-1:0]         era_pc,
    output logic [csr_pkg::PLV_W-1:0]          crmd_plv,
    output logic                               crmd_ie,
    output logic [csr_pkg::INT_W-1:0]          lie,
    output logic [csr_pkg::SWI_W-1:0]          swi
);

    logic                                      crmd_da;
    logic                                      crmd_pg;
    logic [csr_pkg::DAT_W-1:0]                 crmd_datf;
    logic [csr_pkg::DAT_W-1:0]                 crmd_datm;
    logic [csr_pkg::PLV_W-1:0]                 prmd_pplv;
    logic                                      prmd_pie;
    logic [csr_pkg::ECODE_W-1:0]               estat_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]            estat_esubcode;
    logic [csr_pkg::INT_W-1:0]                 estat_is;
    logic [csr_pkg::DATA_W-1:0]                era;
    logic [csr_pkg::DATA_W-1:0]                badv;
    logic [csr_pkg::DATA_W-1:csr_pkg::EENTRY_LSB] eentry_va;
    logic [csr_pkg::DATA_W-1:0]                save_q [4];

    logic [csr_pkg::DATA_W-1:0]                crmd_rdata;
    logic [csr_pkg::DATA_W-1:0]                prmd_rdata;
    logic [csr_pkg::DATA_W-1:0]                eentry_rdata;
    logic [csr_pkg::DATA_W-1:0]                wr_data;
    logic                                      badv_from_pc;
    logic                                      we_crmd;
    logic                                      we_prmd;
    logic                                      we_ecfg;
    logic                                      we_estat;
    logic                                      we_era;
    logic                                      we_badv;
    logic                                      we_eentry;
    logic                                      we_save;

    // Merge against the current read value of the addressed register
    assign wr_data = (csr_wvalue & csr_wmask) | (exc_rdata & ~csr_wmask);

    assign we_crmd   = csr_we && (csr_num == csr_pkg::CSR_CRMD);
    assign we_prmd   = csr_we && (csr_num == csr_pkg::CSR_PRMD);
    assign we_ecfg   = csr_we && (csr_num == csr_pkg::CSR_ECFG);
    assign we_estat  = csr_we && (csr_num == csr_pkg::CSR_ESTAT);
    assign we_era    = csr_we && (csr_num == csr_pkg::CSR_ERA);
    assign we_badv   = csr_we && (csr_num == csr_pkg::CSR_BADV);
    assign we_eentry = csr_we && (csr_num == csr_pkg::CSR_EENTRY);
    assign we_save   = csr_we && (csr_num inside {csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
                                                  csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3});

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= csr_pkg::CRMD_PLV_RST;
            crmd_ie   <= csr_pkg::CRMD_IE_RST;
            crmd_da   <= csr_pkg::CRMD_DA_RST;
            crmd_pg   <= csr_pkg::CRMD_PG_RST;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (ex_valid) begin
            // Enter kernel mode with interrupts off
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (we_crmd) begin
            crmd_plv  <= wr_data[csr_pkg::CRMD_PLV_LSB +: csr_pkg::PLV_W];
            crmd_ie   <= wr_data[csr_pkg::CRMD_IE_BIT];
            crmd_da   <= wr_data[csr_pkg::CRMD_DA_BIT];
            crmd_pg   <= wr_data[csr_pkg::CRMD_PG_BIT];
            crmd_datf <= wr_data[csr_pkg::CRMD_DATF_LSB +: csr_pkg::DAT_W];
            crmd_datm <= wr_data[csr_pkg::CRMD_DATM_LSB +: csr_pkg::DAT_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (ex_valid) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (we_prmd) begin
            prmd_pplv <= wr_data[csr_pkg::CRMD_PLV_LSB +: csr_pkg::PLV_W];
            prmd_pie  <= wr_data[csr_pkg::CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
            swi <= '0;
        end else begin
            if (we_ecfg)
                lie <= wr_data[csr_pkg::INT_W-1:0];
            if (we_estat)
                swi <= wr_data[csr_pkg::SWI_W-1:0];
        end
    end

    // Every kept code is an address-type code
    assign badv_from_pc = (ecode == csr_pkg::ECODE_PIF)
                       || (ecode == csr_pkg::ECODE_ADE && esubcode == csr_pkg::ESUBCODE_ADEF);

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            estat_ecode    <= ecode;
            estat_esubcode <= esubcode;
            era            <= ex_pc;
        end else if (we_era) begin
            era <= wr_data;
        end
        if (ex_valid)
            badv <= badv_from_pc ? ex_pc : ex_vaddr;
        else if (we_badv)
            badv <= wr_data;
        if (we_eentry)
            eentry_va <= wr_data[csr_pkg::DATA_W-1:csr_pkg::EENTRY_LSB];
        if (we_save)
            save_q[csr_num[1:0]] <= wr_data;
    end

    always_comb begin
        crmd_rdata = '0;
        crmd_rdata[csr_pkg::CRMD_PLV_LSB +: csr_pkg::PLV_W]  = crmd_plv;
        crmd_rdata[csr_pkg::CRMD_IE_BIT]                     = crmd_ie;
        crmd_rdata[csr_pkg::CRMD_DA_BIT]                     = crmd_da;
        crmd_rdata[csr_pkg::CRMD_PG_BIT]                     = crmd_pg;
        crmd_rdata[csr_pkg::CRMD_DATF_LSB +: csr_pkg::DAT_W] = crmd_datf;
        crmd_rdata[csr_pkg::CRMD_DATM_LSB +: csr_pkg::DAT_W] = crmd_datm;
        prmd_rdata = '0;
        prmd_rdata[csr_pkg::CRMD_PLV_LSB +: csr_pkg::PLV_W]  = prmd_pplv;
        prmd_rdata[csr_pkg::CRMD_IE_BIT]                     = prmd_pie;
        // Software bits plus the timer line from the timer block
        estat_is = '0;
        estat_is[csr_pkg::SWI_W-1:0]         = swi;
        estat_is[csr_pkg::TIMER_INT_BIT]     = timer_int;
        eentry_rdata = {eentry_va, {csr_pkg::EENTRY_LSB{1'b0}}};
    end

    always_comb begin
        exc_rdata = '0;
        exc_hit   = 1'b1;
        case (csr_num)
            csr_pkg::CSR_CRMD:   exc_rdata = crmd_rdata;
            csr_pkg::CSR_PRMD:   exc_rdata = prmd_rdata;
            csr_pkg::CSR_ECFG:   exc_rdata = {{(csr_pkg::DATA_W-csr_pkg::INT_W){1'b0}}, lie};
            csr_pkg::CSR_ESTAT:  exc_rdata = {1'b0, estat_esubcode, estat_ecode, 3'b000, estat_is};
            csr_pkg::CSR_ERA:    exc_rdata = era;
            csr_pkg::CSR_BADV:   exc_rdata = badv;
            csr_pkg::CSR_EENTRY: exc_rdata = eentry_rdata;
            csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3: exc_rdata = save_q[csr_num[1:0]];
            default:             exc_hit   = 1'b0;
        endcase
    end

    assign ex_entry = eentry_rdata;
    assign era_pc   = era;

    // The writeback stage retires at most one of these per cycle
    assert property (@(posedge clk) disable iff (reset) !(ex_valid && ertn_flush))
        else $error("exception and ertn pulses overlap");

endmodule

/* source/csr_file.sv */
module csr_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           csr_we,
    input  csr_pkg::csr_num_e              csr_num,
    input  logic [csr_pkg::DATA_W-1:0]     csr_wvalue,
    input  logic [csr_pkg::DATA_W-1:0]     csr_wmask,
    input  logic                           ex_valid,
    input  logic [csr_pkg::DATA_W-1:0]     ex_pc,
    input  logic [csr_pkg::DATA_W-1:0]     ex_vaddr,
    input  csr_pkg::ecode_e                ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0] esubcode,
    input  logic                           ertn_flush,
    output logic [csr_pkg::DATA_W-1:0]     csr_rvalue,
    output logic [csr_pkg::DATA_W-1:0]     ex_entry,
    output logic [csr_pkg::DATA_W-1:0]     era_pc,
    output logic [csr_pkg::PLV_W-1:0]      crmd_plv,
    output logic                           int_pending
);

    logic [csr_pkg::DATA_W-1:0] exc_rdata;
    logic                       exc_hit;
    logic [csr_pkg::SWI_W-1:0]  swi;
    logic [csr_pkg::INT_W-1:0]  lie;
    logic                       crmd_ie;
    logic [csr_pkg::DATA_W-1:0] timer_rdata;
    logic                       timer_hit;
    logic                       timer_int;

    csr_exception_regs csr_exception_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wvalue (csr_wvalue),
        .csr_wmask  (csr_wmask),
        .ex_valid   (ex_valid),
        .ertn_flush (ertn_flush),
        .ex_pc      (ex_pc),
        .ex_vaddr   (ex_vaddr),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .timer_int  (timer_int),
        .exc_rdata  (exc_rdata),
        .exc_hit    (exc_hit),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc),
        .crmd_plv   (crmd_plv),
        .crmd_ie    (crmd_ie),
        .lie        (lie),
        .swi        (swi)
    );

    csr_timer csr_timer_inst (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wvalue  (csr_wvalue),
        .csr_wmask   (csr_wmask),
        .timer_rdata (timer_rdata),
        .timer_hit   (timer_hit),
        .timer_int   (timer_int)
    );

    csr_read_mux csr_read_mux_inst (
        .exc_rdata   (exc_rdata),
        .exc_hit     (exc_hit),
        .timer_rdata (timer_rdata),
        .timer_hit   (timer_hit),
        .swi         (swi),
        .timer_int   (timer_int),
        .lie         (lie),
        .crmd_ie     (crmd_ie),
        .csr_rvalue  (csr_rvalue),
        .int_pending (int_pending)
    );

endmodule

/* source/csr_read_mux.sv */
module csr_read_mux (
    input  logic [csr_pkg::DATA_W-1:0] exc_rdata,
    input  logic                       exc_hit,
    input  logic [csr_pkg::DATA_W-1:0] timer_rdata,
    input  logic                       timer_hit,
    input  logic [csr_pkg::SWI_W-1:0]  swi,
    input  logic                       timer_int,
    input  logic [csr_pkg::INT_W-1:0]  lie,
    input  logic                       crmd_ie,
    output logic [csr_pkg::DATA_W-1:0] csr_rvalue,
    output logic                       int_pending
);

    logic [csr_pkg::INT_W-1:0] pending_vec;

    // Unowned numbers read as zero
    always_comb begin
        if (exc_hit)
            csr_rvalue = exc_rdata;
        else if (timer_hit)
            csr_rvalue = timer_rdata;
        else
            csr_rvalue = '0;
    end

    always_comb begin
        pending_vec = '0;
        pending_vec[csr_pkg::SWI_W-1:0]     = swi;
        pending_vec[csr_pkg::TIMER_INT_BIT] = timer_int;
    end

    // Global enable gates the locally enabled sources
    assign int_pending = crmd_ie && |(pending_vec & lie);

    // Both blocks decode disjoint CSR numbers
    always_comb begin
        assert final (!(exc_hit && timer_hit))
            else $error("two register blocks claim the same CSR number");
    end

endmodule

/* tb.f */
+incdir+tests
common/csr_pkg.sv
exception/csr_exception_regs.sv
timer/csr_timer.sv
source/csr_read_mux.sv
source/csr_file.sv
tests/csr_file_tb.sv

/* tests/csr_ref_model.svh */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Read layouts
//   CRMD   [1:0] PLV, [2] IE, [3] DA, [4] PG, [6:5] DATF, [8:7] DATM
//   PRMD   [1:0] PPLV, [2] PIE
//   ECFG   [12:0] LIE
//   ESTAT  [1:0] SWI, [11] timer, [21:16] Ecode, [30:22] EsubCode
//   EENTRY [31:6] entry address
//   TCFG   [0] EN, [1] PERIODIC, [31:2] INITVAL
//   TVAL   counter, TICLR reads zero

logic [1:0]  m_plv;
logic        m_ie;
logic        m_da;
logic        m_pg;
logic [1:0]  m_datf;
logic [1:0]  m_datm;
logic [1:0]  m_pplv;
logic        m_pie;
logic [12:0] m_lie;
logic [1:0]  m_swi;
logic [5:0]  m_ecode;
logic [8:0]  m_esub;
logic [31:0] m_era;
logic [31:0] m_badv;
logic [31:0] m_eentry;
logic [31:0] m_save [4];
logic [31:0] m_tcfg;
logic [31:0] m_tval;
logic        m_tint;

function automatic logic [31:0] expected_rvalue(input csr_pkg::csr_num_e num);
    case (num)
        csr_pkg::CSR_CRMD:   return {23'b0, m_datm, m_datf, m_pg, m_da, m_ie, m_plv};
        csr_pkg::CSR_PRMD:   return {29'b0, m_pie, m_pplv};
        csr_pkg::CSR_ECFG:   return {19'b0, m_lie};
        csr_pkg::CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 4'b0, m_tint, 9'b0, m_swi};
        csr_pkg::CSR_ERA:    return m_era;
        csr_pkg::CSR_BADV:   return m_badv;
        csr_pkg::CSR_EENTRY: return {m_eentry[31:6], 6'b0};
        csr_pkg::CSR_SAVE0:  return m_save[0];
        csr_pkg::CSR_SAVE1:  return m_save[1];
        csr_pkg::CSR_SAVE2:  return m_save[2];
        csr_pkg::CSR_SAVE3:  return m_save[3];
        csr_pkg::CSR_TCFG:   return m_tcfg;
        csr_pkg::CSR_TVAL:   return m_tval;
        default:             return 32'h0;
    endcase
endfunction

function automatic logic expected_pending();
    logic [12:0] sources;
    sources = '0;
    sources[1:0] = m_swi;
    sources[11] = m_tint;
    return m_ie && |(sources & m_lie);
endfunction

task automatic step_model();
    logic [31:0] wdata;
    logic        bad_pc;
    wdata = (csr_wvalue & csr_wmask) | (expected_rvalue(csr_num) & ~csr_wmask);
    bad_pc = (ecode == csr_pkg::ECODE_PIF) || (ecode == csr_pkg::ECODE_ADE && esubcode == 9'h0);
    if (reset) begin
        m_plv = 2'b00;
        m_ie = 1'b0;
        m_da = 1'b1;
        m_pg = 1'b0;
        m_datf = 2'b00;
        m_datm = 2'b00;
        m_pplv = 2'b00;
        m_pie = 1'b0;
        m_lie = '0;
        m_swi = '0;
        m_tcfg = '0;
        m_tval = 32'hffff_ffff;
        m_tint = 1'b0;
    end else begin
        // Interrupt bit looks at the counter before this edge
        if (csr_we && csr_num == csr_pkg::CSR_TICLR && csr_wvalue[0] && csr_wmask[0])
            m_tint = 1'b0;
        else if (m_tval == 32'h0)
            m_tint = 1'b1;
        if (csr_we && csr_num == csr_pkg::CSR_TCFG && wdata[0])
            m_tval = {wdata[31:2], 2'b00};
        else if (m_tcfg[0] && m_tval != 32'hffff_ffff)
            m_tval = (m_tval == 32'h0 && m_tcfg[1]) ? {m_tcfg[31:2], 2'b00} : m_tval - 1;
        if (csr_we && csr_num == csr_pkg::CSR_TCFG)
            m_tcfg = wdata;
        if (ex_valid) begin
            m_pplv = m_plv;
            m_pie = m_ie;
            m_plv = 2'b00;
            m_ie = 1'b0;
            m_ecode = ecode;
            m_esub = esubcode;
            m_era = ex_pc;
            // All tested codes are address codes
            m_badv = bad_pc ? ex_pc : ex_vaddr;
        end else if (ertn_flush) begin
            m_plv = m_pplv;
            m_ie = m_pie;
        end
        if (csr_we) begin
            case (csr_num)
                csr_pkg::CSR_CRMD: begin
                    if (!ex_valid && !ertn_flush) begin
                        {m_datm, m_datf, m_pg, m_da, m_ie, m_plv} = wdata[8:0];
                    end
                end
                csr_pkg::CSR_PRMD: begin
                    if (!ex_valid)
                        {m_pie, m_pplv} = wdata[2:0];
                end
                csr_pkg::CSR_ECFG:   m_lie = wdata[12:0];
                csr_pkg::CSR_ESTAT:  m_swi = wdata[1:0];
                csr_pkg::CSR_ERA:    m_era = ex_valid ? m_era : wdata;
                csr_pkg::CSR_BADV:   m_badv = ex_valid ? m_badv : wdata;
                csr_pkg::CSR_EENTRY: m_eentry = wdata;
                csr_pkg::CSR_SAVE0:  m_save[0] = wdata;
                csr_pkg::CSR_SAVE1:  m_save[1] = wdata;
                csr_pkg::CSR_SAVE2:  m_save[2] = wdata;
                csr_pkg::CSR_SAVE3:  m_save[3] = wdata;
                default: ;
            endcase
        end
    end
endtask

`endif

/* tests/csr_file_tb.sv */
module csr_file_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    localparam int TIMER_CYCLES  = 70;
    localparam int RANDOM_CYCLES = 3000;
    localparam int TIMEOUT = (RESET_CYCLES + TIMER_CYCLES + RANDOM_CYCLES + 100) * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic              csr_we;
    csr_pkg::csr_num_e csr_num;
    logic [31:0]       csr_wvalue;
    logic [31:0]       csr_wmask;
    logic              ex_valid;
    logic [31:0]       ex_pc;
    logic [31:0]       ex_vaddr;
    csr_pkg::ecode_e   ecode;
    logic [8:0]        esubcode;
    logic              ertn_flush;
    logic [31:0]       csr_rvalue;
    logic [31:0]       ex_entry;
    logic [31:0]       era_pc;
    logic [1:0]        crmd_plv;
    logic              int_pending;
    integer            seed;

    csr_pkg::csr_num_e csr_list [14] = '{
        csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
        csr_pkg::CSR_ERA, csr_pkg::CSR_BADV, csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0,
        csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3, csr_pkg::CSR_TCFG,
        csr_pkg::CSR_TVAL, csr_pkg::CSR_TICLR
    };
    csr_pkg::ecode_e code_list [8] = '{
        csr_pkg::ECODE_ADE, csr_pkg::ECODE_ALE, csr_pkg::ECODE_PIL, csr_pkg::ECODE_PIS,
        csr_pkg::ECODE_PIF, csr_pkg::ECODE_PME, csr_pkg::ECODE_PPI, csr_pkg::ECODE_TLBR
    };

    `include "csr_ref_model.svh"

    csr_file csr_file_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        compare_value(csr_rvalue, expected_rvalue(csr_num), $sformatf("read of CSR %h", csr_num));
        compare_value(ex_entry, {m_eentry[31:6], 6'b0}, "ex_entry");
        compare_value(era_pc, m_era, "era_pc");
        compare_value({30'b0, crmd_plv}, {30'b0, m_plv}, "crmd_plv");
        compare_value({31'b0, int_pending}, {31'b0, expected_pending()}, "int_pending");
    endtask

    task automatic idle_inputs();
        csr_we = 1'b0;
        ex_valid = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic write_csr(input csr_pkg::csr_num_e num, input logic [31:0] value,
                             input logic [31:0] mask);
        idle_inputs();
        csr_we = 1'b1;
        csr_num = num;
        csr_wvalue = value;
        csr_wmask = mask;
    endtask

    // Model follows the rising edge, outputs checked at the falling edge
    task automatic tick();
        @(posedge clk);
        step_model();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic random_cycle();
        int pick;
        idle_inputs();
        csr_num = csr_list[$unsigned($random(seed)) % 14];
        pick = $unsigned($random(seed)) % 16;
        if (pick >= 6 && pick < 13) begin
            csr_we = 1'b1;
            csr_wvalue = $random(seed);
            csr_wmask = $random(seed);
            // Short periods so timers run out often
            if (csr_num == csr_pkg::CSR_TCFG)
                csr_wvalue = csr_wvalue & 32'h3f;
        end else if (pick >= 13 && pick < 15) begin
            ex_valid = 1'b1;
            ecode = code_list[$unsigned($random(seed)) % 8];
            esubcode = $random(seed);
            if ($random(seed) & 1)
                esubcode = 9'h0;
            ex_pc = $random(seed);
            ex_vaddr = $random(seed);
        end else if (pick == 15) begin
            ertn_flush = 1'b1;
        end
    endtask

    initial begin
        seed = 32'h5eb1d37d;
        clk = 1'b0;
        reset = 1'b1;
        idle_inputs();
        csr_num = csr_pkg::CSR_CRMD;
        csr_wvalue = '0;
        csr_wmask = '0;
        ex_pc = '0;
        ex_vaddr = '0;
        ecode = csr_pkg::ECODE_ADE;
        esubcode = '0;
        repeat (RESET_CYCLES) tick();
        compare_value(csr_rvalue, 32'h0000_0008, "CRMD after reset");
        compare_value({31'b0, int_pending}, 32'h0, "int_pending after reset");
        reset = 1'b0;

        // Timer line enabled so int_pending follows it every cycle
        write_csr(csr_pkg::CSR_ECFG, 32'h0000_0800, '1);
        tick();
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
        tick();

        // One-shot, INITVAL 3
        write_csr(csr_pkg::CSR_TCFG, 32'h0000_000d, '1);
        tick();
        idle_inputs();
        csr_num = csr_pkg::CSR_TVAL;
        repeat (20) tick();
        compare_value(csr_rvalue, 32'hffff_ffff, "TVAL after one-shot expiry");
        csr_num = csr_pkg::CSR_ESTAT;
        tick();
        compare_value({31'b0, csr_rvalue[11]}, 32'h1, "ESTAT timer bit after expiry");

        // Periodic, INITVAL 2, with a clear on every cycle including the reload cycles
        write_csr(csr_pkg::CSR_TCFG, 32'h0000_000b, '1);
        tick();
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        repeat (30) tick();
        write_csr(csr_pkg::CSR_TCFG, 32'h0, '1);
        tick();

        repeat (RANDOM_CYCLES) begin
            random_cycle();
            tick();
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* timer/csr_timer.sv */
module csr_timer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       csr_we,
    input  csr_pkg::csr_num_e          csr_num,
    input  logic [csr_pkg::DATA_W-1:0] csr_wvalue,
    input  logic [csr_pkg::DATA_W-1:0] csr_wmask,
    output logic [csr_pkg::DATA_W-1:0] timer_rdata,
    output logic                       timer_hit,
    output logic                       timer_int
);

    logic                                                     tcfg_en;
    logic                                                     tcfg_periodic;
    logic [csr_pkg::DATA_W-csr_pkg::TCFG_INITVAL_LSB-1:0]     tcfg_initval;
    logic [csr_pkg::DATA_W-1:0]                               timer_cnt;
    logic [csr_pkg::DATA_W-1:0]                               wr_data;
    logic                                                     tcfg_wr;
    logic                                                     ticlr_clr;

    assign wr_data = (csr_wvalue & csr_wmask) | (timer_rdata & ~csr_wmask);
    assign tcfg_wr = csr_we && (csr_num == csr_pkg::CSR_TCFG);

    // Only a set CLR bit under a set mask bit clears the interrupt
    assign ticlr_clr = csr_we && (csr_num == csr_pkg::CSR_TICLR)
                    && csr_wvalue[csr_pkg::TICLR_CLR_BIT] && csr_wmask[csr_pkg::TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_wr) begin
            tcfg_en       <= wr_data[csr_pkg::TCFG_EN_BIT];
            tcfg_periodic <= wr_data[csr_pkg::TCFG_PERIODIC_BIT];
            tcfg_initval  <= wr_data[csr_pkg::DATA_W-1:csr_pkg::TCFG_INITVAL_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= csr_pkg::TIMER_IDLE;
        end else if (tcfg_wr && wr_data[csr_pkg::TCFG_EN_BIT]) begin
            timer_cnt <= {wr_data[csr_pkg::DATA_W-1:csr_pkg::TCFG_INITVAL_LSB],
                          {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
        end else if (tcfg_en && timer_cnt != csr_pkg::TIMER_IDLE) begin
            // One-shot wraps to idle and parks there
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
            else
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (ticlr_clr)
            timer_int <= 1'b0;
        else if (timer_cnt == '0)
            timer_int <= 1'b1;
    end

    always_comb begin
        timer_rdata = '0;
        timer_hit   = 1'b1;
        case (csr_num)
            csr_pkg::CSR_TCFG:  timer_rdata = {tcfg_initval, tcfg_periodic, tcfg_en};
            csr_pkg::CSR_TVAL:  timer_rdata = timer_cnt;
            csr_pkg::CSR_TICLR: timer_rdata = '0;
            default:            timer_hit   = 1'b0;
        endcase
    end

    // Counter frozen while disabled, unless a write reloads it
    assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !(tcfg_wr && wr_data[csr_pkg::TCFG_EN_BIT])) |=> $stable(timer_cnt))
        else $error("timer counter moved while disabled");

endmodule
